// ==== sim.f ====
+incdir+design
design/rvj1_defines.sv
design/rvj1_dec.sv
design/rvj1_regfile.sv
design/rvj1_alu.sv
design/rvj1_core.sv
verification/rvj1_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run with Verilator from the project root; the exit status is that of the run
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module rvj1_tb -f sim.f -o rvj1_sim &&
  ./obj_dir/rvj1_sim &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }

// ==== verification/rvj1_tb.sv ====
// Random RV32I integer stream against a one-cycle writeback model; stops at the first error
`timescale 1ns/10ps
`include "rvj1_params.svh"

module rvj1_tb import rvj1_defines::*; ();

  ////////////////////////////////////////////////////////////////////////////
  // Run length and ISA encodings
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_INSTR   = 2000;
  localparam int WATCHDOG_NS = 20 * NUM_INSTR * 10;   // 20 cycles per instruction

  localparam logic [6:0] OPC_OPIMM = 7'b0010011;
  localparam logic [6:0] OPC_OP    = 7'b0110011;
  localparam logic [6:0] OPC_LUI   = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC = 7'b0010111;
  localparam logic [6:0] F7_ALT    = 7'b0100000;      // SUB, SRA, SRAI

  logic    clk_i;
  logic    rstn_i;
  xlen_t   ifu_instr_i;
  xlen_t   ifu_pc_i;
  logic    ifu_valid_i;
  logic    ifu_ready_o;
  logic    stall_i;
  retire_t retire_o;

  integer  seed;
  xlen_t   model_regs [0:`RVJ1_NREGS-1];   // x0 never written
  retire_t exp_q [$];                      // Accepted, not yet retired
  xlen_t   instr_q [$];                    // Matching words for messages
  int      accepted;
  int      retired;

  rvj1_core i_dut (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .ifu_instr_i (ifu_instr_i),
    .ifu_pc_i    (ifu_pc_i),
    .ifu_valid_i (ifu_valid_i),
    .ifu_ready_o (ifu_ready_o),
    .stall_i     (stall_i),
    .retire_o    (retire_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;   // 10 ns period
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: only %0d of %0d instructions retired", retired, NUM_INSTR);
    stop_run();
  end

  task automatic stop_run();
    $display("Test failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input xlen_t got, input xlen_t want, input string what);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
      stop_run();
    end
  endtask

  task automatic check_rd(input ralen_t got, input ralen_t want, input string what);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is x%0d, expected x%0d", $time, what, got, want);
      stop_run();
    end
  endtask

  task automatic check_flag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, want);
      stop_run();
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  function automatic xlen_t rand_word();
    return $random(seed);
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return rand_word() % n;
  endfunction

  function automatic xlen_t rand_pc();
    xlen_t w;
    w = rand_word();
    return {w[31:2], 2'b00};   // Word aligned
  endfunction

  // Half the picks land in x0..x7 so results get reused soon
  function automatic ralen_t pick_reg();
    xlen_t w;
    w = rand_word();
    if (w[8]) begin
      return {2'b00, w[2:0]};
    end
    return w[4:0];
  endfunction

  function automatic xlen_t gen_instr();
    xlen_t       w;
    xlen_t       w2;
    xlen_t       instr;
    int unsigned kind;
    logic [6:0]  opc;
    logic [6:0]  f7;
    logic [2:0]  f3;
    ralen_t      rd;
    ralen_t      rs1;
    ralen_t      rs2;
    w    = rand_word();
    w2   = rand_word();
    kind = pick(100);
    rd   = pick_reg();
    rs1  = pick_reg();
    rs2  = pick_reg();
    f3   = w[2:0];
    f7   = w[3] ? F7_ALT : 7'b0000000;
    if (kind < 35) begin                                  // OP-IMM
      if (f3 == 3'b001) begin
        instr = {7'b0000000, w[24:20], rs1, f3, rd, OPC_OPIMM};
      end else if (f3 == 3'b101) begin
        instr = {f7, w[24:20], rs1, f3, rd, OPC_OPIMM};   // SRLI or SRAI
      end else begin
        instr = {w[31:20], rs1, f3, rd, OPC_OPIMM};
      end
    end else if (kind < 70) begin                         // OP
      if ((f3 != 3'b000) && (f3 != 3'b101)) begin
        f7 = 7'b0000000;
      end
      instr = {f7, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 80) begin                         // LUI, AUIPC
      opc   = w[4] ? OPC_LUI : OPC_AUIPC;
      instr = {w[31:12], rd, opc};
    end else if (kind < 90) begin                         // Unknown opcode
      opc = w[30:24];
      if ((opc == OPC_OPIMM) || (opc == OPC_OP) || (opc == OPC_LUI) || (opc == OPC_AUIPC)) begin
        opc = 7'b1111111;
      end
      instr = {w2[31:7], opc};
    end else begin                                        // Shift, bad funct7
      f7 = w2[6:0];
      if ((f7 == 7'b0000000) || (f7 == F7_ALT)) begin
        f7 = 7'b0000001;
      end
      f3    = w[6] ? 3'b001 : 3'b101;
      opc   = w[5] ? OPC_OPIMM : OPC_OP;
      instr = {f7, rs2, rs1, f3, rd, opc};
    end
    return instr;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Executes one accepted instruction and updates the model registers
  function automatic retire_t model_exec(input xlen_t instr, input xlen_t pc);
    retire_t    r;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic [4:0] sh;
    xlen_t      a;
    xlen_t      b;
    xlen_t      res;
    logic       legal;
    logic       alt;
    opc   = instr[6:0];
    f3    = instr[14:12];
    f7    = instr[31:25];
    a     = model_regs[instr[19:15]];
    b     = '0;
    res   = '0;
    legal = 1'b0;
    alt   = 1'b0;
    if ((opc == OPC_OPIMM) || (opc == OPC_OP)) begin
      if (opc == OPC_OPIMM) begin
        b     = {{20{instr[31]}}, instr[31:20]};
        legal = (f3 == 3'b001) ? (f7 == 7'b0000000) :
                (f3 == 3'b101) ? ((f7 == 7'b0000000) || (f7 == F7_ALT)) : 1'b1;
        alt   = (f3 == 3'b101) && (f7 == F7_ALT);        // No SUBI
      end else begin
        b     = model_regs[instr[24:20]];
        legal = (f7 == 7'b0000000) ||
                ((f7 == F7_ALT) && ((f3 == 3'b000) || (f3 == 3'b101)));
        alt   = (f7 == F7_ALT);
      end
      sh = b[4:0];
      case (f3)
        3'b000: res = alt ? (a - b) : (a + b);
        3'b001: res = a << sh;
        3'b010: res = {31'b0, (a[31] != b[31]) ? a[31] : (a < b)};   // Signed
        3'b011: res = {31'b0, (a < b)};
        3'b100: res = a ^ b;
        3'b101: res = (a >> sh) | ((alt && a[31]) ? ~(32'hffffffff >> sh) : 32'h0);
        3'b110: res = a | b;
        default: res = a & b;
      endcase
    end else if (opc == OPC_LUI) begin
      legal = 1'b1;
      res   = {instr[31:12], 12'h000};
    end else if (opc == OPC_AUIPC) begin
      legal = 1'b1;
      res   = pc + {instr[31:12], 12'h000};
    end
    r.retire  = 1'b1;
    r.illegal = !legal;
    r.write   = legal && (instr[11:7] != 5'd0);
    r.rd      = instr[11:7];
    r.data    = res;
    if (r.write) begin
      model_regs[r.rd] = res;
    end
    return r;
  endfunction

  task automatic check_retire();
    retire_t want;
    xlen_t   instr;
    want  = exp_q.pop_front();
    instr = instr_q.pop_front();
    check_flag(retire_o.illegal, want.illegal, $sformatf("illegal of %h", instr));
    check_flag(retire_o.write, want.write, $sformatf("write of %h", instr));
    check_rd(retire_o.rd, want.rd, $sformatf("rd of %h", instr));
    if (!want.illegal) begin
      check_data(retire_o.data, want.data, $sformatf("data of %h", instr));
    end
    retired++;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    xlen_t next_instr;
    xlen_t next_pc;
    seed        = 32'hff76a980;
    rstn_i      = 1'b0;
    ifu_instr_i = '0;
    ifu_pc_i    = '0;
    ifu_valid_i = 1'b0;
    stall_i     = 1'b0;
    accepted    = 0;
    retired     = 0;
    for (int i = 0; i < `RVJ1_NREGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rstn_i     = 1'b1;
    next_instr = gen_instr();
    next_pc    = rand_pc();

    while (retired < NUM_INSTR) begin
      @(negedge clk_i);
      stall_i     = (pick(5) == 0);                          // 1/5
      ifu_valid_i = (accepted < NUM_INSTR) && (pick(4) != 0);   // 3/4
      ifu_instr_i = next_instr;
      ifu_pc_i    = next_pc;
      #1;   // Settled until the next rising edge
      check_flag(ifu_ready_o, !stall_i, "ifu_ready_o");
      // Held instruction retires whenever there is no freeze
      check_flag(retire_o.retire, (exp_q.size() != 0) && !stall_i, "retire");
      if (retire_o.retire) begin
        check_retire();
      end
      if (ifu_valid_i && ifu_ready_o) begin
        exp_q.push_back(model_exec(ifu_instr_i, ifu_pc_i));
        instr_q.push_back(ifu_instr_i);
        accepted++;
        next_instr = gen_instr();
        next_pc    = rand_pc();
      end
    end

    @(negedge clk_i);
    ifu_valid_i = 1'b0;
    #1;
    // Drained pipeline retires nothing more
    check_flag(retire_o.retire, 1'b0, "retire after the last instruction");
    if ((exp_q.size() != 0) || (accepted != NUM_INSTR)) begin
      $display("Run ended with %0d accepted and %0d not retired", accepted, exp_q.size());
      stop_run();
    end else begin
      $display("Test completed successfully");
      $finish;
    end
  end

endmodule

// ==== design/rvj1_core.sv ====
// Single-issue RV32I integer slice with one cycle latency; no hazards since writeback precedes the next read
`timescale 1ns/10ps

module rvj1_core import rvj1_defines::*; (
  input  logic    clk_i,
  input  logic    rstn_i,

  // Instruction fetch side
  input  xlen_t   ifu_instr_i,
  input  xlen_t   ifu_pc_i,
  input  logic    ifu_valid_i,
  output logic    ifu_ready_o,

  input  logic    stall_i,       // Downstream freeze

  // Trace of retired instructions
  output retire_t retire_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////////////////////////////////////////

  dec_ctrl_t dec;        // Held decode
  logic      exe_fire;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  // Decode and control
  rvj1_dec i_dec (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .ifu_instr_i (ifu_instr_i),
    .ifu_pc_i    (ifu_pc_i),
    .ifu_valid_i (ifu_valid_i),
    .ifu_ready_o (ifu_ready_o),
    .stall_i     (stall_i),
    .dec_o       (dec),
    .exe_fire_o  (exe_fire)
  );

  // Operands read in the cycle after decode
  rvj1_regfile i_regfile (
    .clk_i     (clk_i),
    .rstn_i    (rstn_i),
    .raddr_a_i (dec.rs1),
    .raddr_b_i (dec.rs2),
    .rdata_a_o (rs1_data),
    .rdata_b_o (rs2_data),
    .wr_i      (retire_o)      // Write back from the retire record
  );

  // Execute and retire
  rvj1_alu i_alu (
    .clk_i      (clk_i),
    .dec_i      (dec),
    .exe_fire_i (exe_fire),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .retire_o   (retire_o)
  );

endmodule

// ==== design/rvj1_alu.sv ====
// Purely combinational execute stage; clk_i only samples the assertions
`timescale 1ns/10ps
`include "rvj1_params.svh"

module rvj1_alu import rvj1_defines::*; (
  input  logic      clk_i,         // Assertion sampling only
  input  dec_ctrl_t dec_i,         // Held decode
  input  logic      exe_fire_i,    // Retires this cycle
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,
  output retire_t   retire_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Operand selection
  ////////////////////////////////////////////////////////////////////////////

  xlen_t                          opa;
  xlen_t                          opb;
  logic [$clog2(`RVJ1_XLEN)-1:0] shamt;    // Low bits of B only
  xlen_t                          result;

  always_comb begin
    case (dec_i.opa_sel)
      OPA_PC:   opa = dec_i.pc;
      OPA_ZERO: opa = '0;
      default:  opa = rs1_data_i;
    endcase
  end

  assign opb   = dec_i.opb_imm ? dec_i.imm : rs2_data_i;
  assign shamt = opb[$clog2(`RVJ1_XLEN)-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Operations
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (dec_i.alu_op)
      ALU_OP_ADD:  result = opa + opb;
      ALU_OP_SUB:  result = opa - opb;
      ALU_OP_SLL:  result = opa << shamt;
      ALU_OP_SLT:  result = xlen_t'($signed(opa) < $signed(opb));
      ALU_OP_SLTU: result = xlen_t'(opa < opb);
      ALU_OP_XOR:  result = opa ^ opb;
      ALU_OP_SRL:  result = opa >> shamt;
      ALU_OP_SRA:  result = xlen_t'($signed(opa) >>> shamt);   // Sign fill
      ALU_OP_OR:   result = opa | opb;
      ALU_OP_AND:  result = opa & opb;
      default:     result = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Retire record
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    retire_o.retire  = exe_fire_i;
    retire_o.illegal = exe_fire_i & dec_i.illegal;
    // x0 writes retire without a register write
    retire_o.write   = exe_fire_i & dec_i.write_rf & (dec_i.rd != '0);
    retire_o.rd      = dec_i.rd;
    retire_o.data    = result;
  end

  // A retiring result is never built from unknown operands
  a_data_known: assert property (@(posedge clk_i)
    retire_o.retire |-> !$isunknown(retire_o.data));

  // Illegal flag from decode and write enable here stay exclusive
  a_write_not_illegal: assert property (@(posedge clk_i)
    retire_o.write |-> !retire_o.illegal);

endmodule

// ==== design/rvj1_regfile.sv ====
// 31 registers plus hard-wired x0; reads are combinational, so a write is seen the next cycle
`timescale 1ns/10ps
`include "rvj1_params.svh"

module rvj1_regfile import rvj1_defines::*; (
  input  logic    clk_i,
  input  logic    rstn_i,

  // Read ports
  input  ralen_t  raddr_a_i,
  input  ralen_t  raddr_b_i,
  output xlen_t   rdata_a_o,
  output xlen_t   rdata_b_o,

  // Write port, straight from the retire record
  input  retire_t wr_i
);

  ////////////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////////////

  xlen_t regs_q [1:`RVJ1_NREGS-1];   // No storage for x0

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 1; i < `RVJ1_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.write && (wr_i.rd != '0)) begin
      regs_q[wr_i.rd] <= wr_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////////////

  // x0 reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

  // Write index from the ALU is known and never x0
  a_wr_idx_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
    wr_i.write |-> (!$isunknown(wr_i.rd) && (wr_i.rd != '0)));

endmodule

// ==== design/rvj1_dec.sv ====
// RV32I OP, OP-IMM, LUI and AUIPC only; any other encoding retires as illegal without a write
`timescale 1ns/10ps
`include "rvj1_params.svh"

module rvj1_dec import rvj1_defines::*; (
  input  logic      clk_i,
  input  logic      rstn_i,

  // Fetch side
  input  xlen_t     ifu_instr_i,   // Raw instruction word
  input  xlen_t     ifu_pc_i,      // pc of that word
  input  logic      ifu_valid_i,
  output logic      ifu_ready_o,

  input  logic      stall_i,       // Freeze from downstream

  // To execute
  output dec_ctrl_t dec_o,         // Registered decode
  output logic      exe_fire_o     // Held instruction retires now
);

  ////////////////////////////////////////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////////////////////////////////////////

  logic [6:0] opcode;
  ralen_t     rd;
  ralen_t     rs1;
  ralen_t     rs2;
  f3_e        funct3;
  logic [6:0] funct7;
  xlen_t      imm_i;     // Also carries shamt in its low bits
  xlen_t      imm_u;
  logic       accept;    // Handshake this cycle
  dec_ctrl_t  dec_d;     // Next decode
  dec_ctrl_t  dec_q;

  assign opcode = ifu_instr_i[6:0];
  assign rd     = ifu_instr_i[11:7];
  assign funct3 = f3_e'(ifu_instr_i[14:12]);
  assign rs1    = ifu_instr_i[19:15];
  assign rs2    = ifu_instr_i[24:20];
  assign funct7 = ifu_instr_i[31:25];

  // I and U immediates, sign extended to XLEN
  assign imm_i = {{(`RVJ1_XLEN-12){ifu_instr_i[31]}}, ifu_instr_i[31:20]};
  assign imm_u = {ifu_instr_i[31:12], 12'h000};

  assign ifu_ready_o = ~stall_i;
  assign accept      = ifu_valid_i & ifu_ready_o;

  ////////////////////////////////////////////////////////////////////////////
  // Combinational decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_d         = '0;
    dec_d.valid   = 1'b1;
    dec_d.illegal = 1'b1;      // Cleared by any legal encoding
    dec_d.rs1     = rs1;
    dec_d.alu_op  = ALU_OP_ADD;
    dec_d.opa_sel = OPA_RS1;
    dec_d.rd      = rd;
    dec_d.imm     = imm_i;
    dec_d.pc      = ifu_pc_i;

    case (opcode)
      OPCODE_OPIMM: begin
        dec_d.opb_imm = 1'b1;
        dec_d.illegal = 1'b0;
        case (funct3)
          F3_ADD_SUB: dec_d.alu_op = ALU_OP_ADD;   // No SUBI
          F3_SLT:     dec_d.alu_op = ALU_OP_SLT;
          F3_SLTU:    dec_d.alu_op = ALU_OP_SLTU;
          F3_XOR:     dec_d.alu_op = ALU_OP_XOR;
          F3_OR:      dec_d.alu_op = ALU_OP_OR;
          F3_AND:     dec_d.alu_op = ALU_OP_AND;
          F3_SLL: begin
            dec_d.alu_op  = ALU_OP_SLL;
            dec_d.illegal = (funct7 != F7_BASE);
          end
          F3_SRL_SRA: begin
            if (funct7 == F7_ALT) begin
              dec_d.alu_op = ALU_OP_SRA;
            end else begin
              dec_d.alu_op = ALU_OP_SRL;
            end
            dec_d.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
          end
          default: dec_d.illegal = 1'b1;
        endcase
      end

      OPCODE_OP: begin
        dec_d.rs2 = rs2;
        // Alternate funct7 only exists for SUB and SRA
        dec_d.illegal = !((funct7 == F7_BASE) ||
                          ((funct7 == F7_ALT) &&
                           ((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA))));
        case (funct3)
          F3_ADD_SUB: begin
            if (funct7 == F7_ALT) begin
              dec_d.alu_op = ALU_OP_SUB;
            end else begin
              dec_d.alu_op = ALU_OP_ADD;
            end
          end
          F3_SRL_SRA: begin
            if (funct7 == F7_ALT) begin
              dec_d.alu_op = ALU_OP_SRA;
            end else begin
              dec_d.alu_op = ALU_OP_SRL;
            end
          end
          F3_SLL:  dec_d.alu_op = ALU_OP_SLL;
          F3_SLT:  dec_d.alu_op = ALU_OP_SLT;
          F3_SLTU: dec_d.alu_op = ALU_OP_SLTU;
          F3_XOR:  dec_d.alu_op = ALU_OP_XOR;
          F3_OR:   dec_d.alu_op = ALU_OP_OR;
          F3_AND:  dec_d.alu_op = ALU_OP_AND;
          default: dec_d.illegal = 1'b1;
        endcase
      end

      OPCODE_LUI: begin
        dec_d.opa_sel = OPA_ZERO;  // 0 + imm
        dec_d.opb_imm = 1'b1;
        dec_d.imm     = imm_u;
        dec_d.illegal = 1'b0;
      end

      OPCODE_AUIPC: begin
        dec_d.opa_sel = OPA_PC;    // pc + imm
        dec_d.opb_imm = 1'b1;
        dec_d.imm     = imm_u;
        dec_d.illegal = 1'b0;
      end

      default: ;                   // Stays illegal
    endcase

    dec_d.write_rf = ~dec_d.illegal;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Decode register
  ////////////////////////////////////////////////////////////////////////////

  // Load on accept, hold under stall, bubble otherwise
  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      dec_q.valid    <= 1'b0;
      dec_q.illegal  <= 1'b0;
      dec_q.write_rf <= 1'b0;
    end else if (accept) begin
      dec_q <= dec_d;
    end else if (!stall_i) begin
      dec_q.valid    <= 1'b0;      // Bubble, payload left as is
      dec_q.illegal  <= 1'b0;
      dec_q.write_rf <= 1'b0;
    end
  end

  assign dec_o      = dec_q;
  assign exe_fire_o = dec_q.valid & ~stall_i;   // Only stall check in the core

  // Fetch is never told ready during a freeze
  a_ready_vs_stall: assert property (@(posedge clk_i) disable iff (!rstn_i)
    stall_i |-> !ifu_ready_o);

  // An illegal decode must never reach the register file
  a_illegal_no_write: assert property (@(posedge clk_i) disable iff (!rstn_i)
    dec_o.illegal |-> !dec_o.write_rf);

endmodule

// ==== design/rvj1_defines.sv ====
// Shared types for the RV32I integer execute slice; no load, store, branch or CSR encodings
`include "rvj1_params.svh"

package rvj1_defines;

  ////////////////////////////////////////////////////////////////////////////
  // Width types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [`RVJ1_XLEN-1:0]  xlen_t;   // Data word, pc or immediate
  typedef logic [`RVJ1_RALEN-1:0] ralen_t;  // Register index

  ////////////////////////////////////////////////////////////////////////////
  // Instruction encodings
  ////////////////////////////////////////////////////////////////////////////

  // Major opcodes handled by the slice
  typedef enum logic [6:0] {
    OPCODE_OPIMM = 7'b0010011,
    OPCODE_OP    = 7'b0110011,
    OPCODE_LUI   = 7'b0110111,
    OPCODE_AUIPC = 7'b0010111
  } opcode_e;

  // funct3 of OP and OP-IMM
  typedef enum logic [2:0] {
    F3_ADD_SUB = 3'b000,  // ADDI too
    F3_SLL     = 3'b001,
    F3_SLT     = 3'b010,
    F3_SLTU    = 3'b011,
    F3_XOR     = 3'b100,
    F3_SRL_SRA = 3'b101,
    F3_OR      = 3'b110,
    F3_AND     = 3'b111
  } f3_e;

  // funct7 values that are legal somewhere
  typedef enum logic [6:0] {
    F7_BASE = 7'b0000000,
    F7_ALT  = 7'b0100000   // SUB, SRA and SRAI
  } f7_e;

  ////////////////////////////////////////////////////////////////////////////
  // Datapath control
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    ALU_OP_ADD, ALU_OP_SUB, ALU_OP_SLL, ALU_OP_SLT, ALU_OP_SLTU,
    ALU_OP_XOR, ALU_OP_SRL, ALU_OP_SRA, ALU_OP_OR, ALU_OP_AND
  } alu_op_e;

  typedef enum logic [1:0] {
    OPA_RS1,   // Register ops
    OPA_PC,    // AUIPC
    OPA_ZERO   // LUI
  } opa_sel_e;

  // Decoded instruction held between decode and execute
  typedef struct packed {
    logic     valid;     // Not a bubble
    logic     illegal;
    ralen_t   rs1;
    ralen_t   rs2;
    alu_op_e  alu_op;
    opa_sel_e opa_sel;
    logic     opb_imm;   // Operand B from imm instead of rs2
    logic     write_rf;
    ralen_t   rd;
    xlen_t    imm;       // Already sign extended
    xlen_t    pc;
  } dec_ctrl_t;

  // One retired instruction, also the register file write
  typedef struct packed {
    logic   retire;
    logic   illegal;
    logic   write;       // Only for rd != x0
    ralen_t rd;
    xlen_t  data;
  } retire_t;

endpackage

// ==== design/rvj1_params.svh ====
// RV32I widths are fixed by the ISA; changing them breaks the decoder field slicing
`ifndef RVJ1_PARAMS_SVH
`define RVJ1_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// Architectural widths
////////////////////////////////////////////////////////////////////////////

// Data, pc, immediate and instruction width
`define RVJ1_XLEN 32

// Register index width
`define RVJ1_RALEN 5

// Architectural registers, x0 included
`define RVJ1_NREGS 32

// Note that shifts use log2 of XLEN bits of operand B,
// so XLEN has to stay a power of two

`endif
